// File: Bender.yml
package:
  name: exec_unit

sources:
  - source/exec_pkg.sv
  - source/alu_unit.sv
  - source/iter_divider.sv
  - source/exec_control.sv
  - source/exec_unit.sv
  - target: simulation
    files:
      - testbench/tb_exec_unit.sv

// File: source/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
	input  exec_pkg::exec_op_e           i_op,
	input  logic [exec_pkg::XLEN-1:0]    i_a,
	input  logic [exec_pkg::XLEN-1:0]    i_b,
	output logic [exec_pkg::XLEN-1:0]    o_result
);
	import exec_pkg::*;

	// Group generate of a 4-bit slice.
	function automatic logic group_gen(input logic [3:0] g, input logic [3:0] p);
		group_gen = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
			| (p[3] & p[2] & p[1] & g[0]);
	endfunction

	// Carry into each bit of a 4-bit slice, bit 0 gets the slice carry-in.
	function automatic logic [3:0] nibble_carry(
		input logic [3:0] g,
		input logic [3:0] p,
		input logic       cin
	);
		logic [3:0] c;
		c[0] = cin;
		c[1] = g[0] | (p[0] & cin);
		c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
		c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
			| (p[2] & p[1] & p[0] & cin);
		nibble_carry = c;
	endfunction

	logic              sub;
	logic [XLEN-1:0]   b_eff;
	logic [XLEN-1:0]   gen;
	logic [XLEN-1:0]   prop;
	logic [XLEN-1:0]   carry;    // Carry into each bit.
	logic [XLEN-1:0]   sum;
	logic [XLEN/8:0]   blk_c;    // Ripple between 8-bit blocks.
	logic              overflow;
	logic              lt_signed;
	logic              lt_unsigned;

	// Compares are a subtract with the sum thrown away.
	assign sub = (i_op == OP_SUB) || (i_op == OP_SLT) || (i_op == OP_SLTU);
	assign b_eff = sub ? ~i_b : i_b;

	assign gen = i_a & b_eff;
	assign prop = i_a | b_eff;
	assign blk_c[0] = sub;

	genvar blk;
	generate
		for (blk = 0; blk < XLEN / 8; blk++) begin : g_blk
			logic g_lo;
			logic p_lo;
			logic g_hi;
			logic p_hi;
			logic c_mid;

			assign g_lo = group_gen(gen[blk*8 +: 4], prop[blk*8 +: 4]);
			assign p_lo = &prop[blk*8 +: 4];
			assign g_hi = group_gen(gen[blk*8+4 +: 4], prop[blk*8+4 +: 4]);
			assign p_hi = &prop[blk*8+4 +: 4];

			assign c_mid = g_lo | (p_lo & blk_c[blk]);    // Into the upper nibble.

			assign carry[blk*8 +: 4] = nibble_carry(gen[blk*8 +: 4], prop[blk*8 +: 4],
				blk_c[blk]);
			assign carry[blk*8+4 +: 4] = nibble_carry(gen[blk*8+4 +: 4],
				prop[blk*8+4 +: 4], c_mid);

			// 8-bit lookahead, then ripple to the next block.
			assign blk_c[blk+1] = g_hi | (p_hi & g_lo) | (p_hi & p_lo & blk_c[blk]);
		end
	endgenerate

	assign sum = i_a ^ b_eff ^ carry;

	assign overflow = (i_a[XLEN-1] == b_eff[XLEN-1]) && (sum[XLEN-1] != i_a[XLEN-1]);
	assign lt_signed = sum[XLEN-1] ^ overflow;
	assign lt_unsigned = ~blk_c[XLEN/8];    // No carry out means a borrow.

	always_comb begin
		case (i_op)
			OP_ADD,
			OP_SUB:  o_result = sum;
			OP_SLT:  o_result = XLEN'(lt_signed);
			OP_SLTU: o_result = XLEN'(lt_unsigned);
			OP_XOR:  o_result = i_a ^ i_b;
			OP_OR:   o_result = i_a | i_b;
			OP_AND:  o_result = i_a & i_b;
			default: o_result = '0;    // Divides go to the divider.
		endcase
	end

endmodule

// File: source/exec_control.sv
`timescale 1ns/1ps

module exec_control (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_req,
	input  exec_pkg::exec_cmd_t          i_cmd,
	output logic                         o_ack,
	output logic [exec_pkg::XLEN-1:0]    o_result,
	output exec_pkg::exec_op_e           o_alu_op,
	output logic [exec_pkg::XLEN-1:0]    o_alu_a,
	output logic [exec_pkg::XLEN-1:0]    o_alu_b,
	input  logic [exec_pkg::XLEN-1:0]    i_alu_result,
	output logic                         o_div_start,
	output exec_pkg::div_cmd_t           o_div_cmd,
	input  logic                         i_div_done,
	input  logic [exec_pkg::XLEN-1:0]    i_div_result
);
	import exec_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ALU,
		ST_DIV,
		ST_ACK
	} state_e;

	state_e     state_q;
	exec_cmd_t  cmd_q;
	logic       is_div;

	assign is_div = i_cmd.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

	// Latched operands feed both units.
	assign o_alu_op = cmd_q.op;
	assign o_alu_a = cmd_q.operand_a;
	assign o_alu_b = cmd_q.operand_b;

	assign o_div_cmd.is_signed = (cmd_q.op == OP_DIV) || (cmd_q.op == OP_REM);
	assign o_div_cmd.want_rem = (cmd_q.op == OP_REM) || (cmd_q.op == OP_REMU);
	assign o_div_cmd.dividend = cmd_q.operand_a;
	assign o_div_cmd.divisor = cmd_q.operand_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			o_ack <= 1'b0;
			o_div_start <= 1'b0;
		end else begin
			o_div_start <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (i_req) begin
						state_q <= is_div ? ST_DIV : ST_ALU;
						o_div_start <= is_div;    // Divider loads on the next edge.
					end
				end
				ST_ALU: state_q <= ST_ACK;
				ST_DIV: begin
					if (i_div_done) begin
						o_ack <= 1'b1;
						state_q <= ST_ACK;
					end
				end
				ST_ACK: begin
					// ALU results arrive here with ack still low.
					if (!o_ack) begin
						o_ack <= 1'b1;
					end else if (!i_req) begin
						o_ack <= 1'b0;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE && i_req)
			cmd_q <= i_cmd;
		if (state_q == ST_ALU)
			o_result <= i_alu_result;
		else if (state_q == ST_DIV && i_div_done)
			o_result <= i_div_result;
	end

	a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
		$rose(o_ack) |-> i_req);

	a_result_held: assert property (@(posedge clk) disable iff (rst)
		$past(o_ack) && o_ack |-> $stable(o_result));

endmodule

// File: source/exec_pkg.sv
package exec_pkg;

	localparam int unsigned XLEN = 32;

	// Restoring divider, one quotient bit per step.
	localparam int unsigned DIV_STEPS = 32;
	localparam int unsigned DIV_CNT_W = 6;    // Holds 0 to DIV_STEPS.

	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_SLT  = 4'd2,
		OP_SLTU = 4'd3,
		OP_XOR  = 4'd4,
		OP_OR   = 4'd5,
		OP_AND  = 4'd6,
		OP_DIV  = 4'd7,
		OP_DIVU = 4'd8,
		OP_REM  = 4'd9,
		OP_REMU = 4'd10
	} exec_op_e;

	// Command carried on the req/ack interface.
	typedef struct packed {
		exec_op_e          op;
		logic [XLEN-1:0]   operand_a;
		logic [XLEN-1:0]   operand_b;
	} exec_cmd_t;

	// Request from the controller to the divider.
	typedef struct packed {
		logic              is_signed;
		logic              want_rem;    // Return remainder instead of quotient.
		logic [XLEN-1:0]   dividend;
		logic [XLEN-1:0]   divisor;
	} div_cmd_t;

endpackage

// File: source/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_req,
	input  exec_pkg::exec_cmd_t          i_cmd,
	output logic                         o_ack,
	output logic [exec_pkg::XLEN-1:0]    o_result
);
	import exec_pkg::*;

	exec_op_e         alu_op;
	logic [XLEN-1:0]  alu_a;
	logic [XLEN-1:0]  alu_b;
	logic [XLEN-1:0]  alu_result;
	logic             div_start;
	div_cmd_t         div_cmd;
	logic             div_done;
	logic [XLEN-1:0]  div_result;

	exec_control u_control (
		.clk          (clk),
		.rst          (rst),
		.i_req        (i_req),
		.i_cmd        (i_cmd),
		.o_ack        (o_ack),
		.o_result     (o_result),
		.o_alu_op     (alu_op),
		.o_alu_a      (alu_a),
		.o_alu_b      (alu_b),
		.i_alu_result (alu_result),
		.o_div_start  (div_start),
		.o_div_cmd    (div_cmd),
		.i_div_done   (div_done),
		.i_div_result (div_result)
	);

	alu_unit u_alu (
		.i_op     (alu_op),
		.i_a      (alu_a),
		.i_b      (alu_b),
		.o_result (alu_result)
	);

	iter_divider u_divider (
		.clk      (clk),
		.rst      (rst),
		.i_start  (div_start),
		.i_cmd    (div_cmd),
		.o_done   (div_done),
		.o_result (div_result)
	);

endmodule

// File: source/iter_divider.sv
`timescale 1ns/1ps

module iter_divider (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         i_start,
	input  exec_pkg::div_cmd_t           i_cmd,
	output logic                         o_done,
	output logic [exec_pkg::XLEN-1:0]    o_result
);
	import exec_pkg::*;

	logic                  busy_q;
	logic [DIV_CNT_W-1:0]  cnt_q;
	logic [XLEN-1:0]       dvd_q;    // Dividend magnitude, consumed MSB first.
	logic [XLEN-1:0]       dvs_q;
	logic [XLEN-1:0]       rem_q;
	logic [XLEN-1:0]       quo_q;
	logic                  neg_quo_q;
	logic                  neg_rem_q;
	logic                  zero_q;
	logic                  want_rem_q;

	logic                  last_step;
	logic [XLEN-1:0]       abs_a;
	logic [XLEN-1:0]       abs_b;
	logic [XLEN:0]         rem_shift;
	logic [XLEN:0]         rem_diff;
	logic                  fits;
	logic [XLEN-1:0]       rem_next;
	logic [XLEN-1:0]       quo_next;
	logic [XLEN-1:0]       quo_fix;
	logic [XLEN-1:0]       rem_fix;

	assign abs_a = (i_cmd.is_signed && i_cmd.dividend[XLEN-1]) ? -i_cmd.dividend
		: i_cmd.dividend;
	assign abs_b = (i_cmd.is_signed && i_cmd.divisor[XLEN-1]) ? -i_cmd.divisor
		: i_cmd.divisor;

	// One restoring step. The extra bit keeps large unsigned divisors exact.
	assign rem_shift = {rem_q, dvd_q[XLEN-1]};
	assign rem_diff = rem_shift - {1'b0, dvs_q};
	assign fits = !rem_diff[XLEN];
	assign rem_next = fits ? rem_diff[XLEN-1:0] : rem_shift[XLEN-1:0];
	assign quo_next = {quo_q[XLEN-2:0], fits};

	assign last_step = (cnt_q == DIV_CNT_W'(DIV_STEPS));

	// With a zero divisor the steps leave |a| as remainder, and the sign fix
	// turns that back into the dividend.
	assign quo_fix = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
	assign rem_fix = neg_rem_q ? -rem_q : rem_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			cnt_q <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy_q <= 1'b1;
				cnt_q <= '0;
			end else if (busy_q) begin
				if (last_step) begin
					busy_q <= 1'b0;
					o_done <= 1'b1;    // Sign fixup cycle.
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_start) begin
			dvd_q <= abs_a;
			dvs_q <= abs_b;
			rem_q <= '0;
			quo_q <= '0;
			neg_quo_q <= i_cmd.is_signed
				&& (i_cmd.dividend[XLEN-1] ^ i_cmd.divisor[XLEN-1]);
			neg_rem_q <= i_cmd.is_signed && i_cmd.dividend[XLEN-1];
			zero_q <= (i_cmd.divisor == '0);
			want_rem_q <= i_cmd.want_rem;
		end else if (busy_q) begin
			if (last_step) begin
				o_result <= want_rem_q ? rem_fix : quo_fix;
			end else begin
				dvd_q <= {dvd_q[XLEN-2:0], 1'b0};
				rem_q <= rem_next;
				quo_q <= quo_next;
			end
		end
	end

	a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
		i_start |-> !busy_q);

	// Done is sampled one edge after the load, all steps and the fixup.
	a_done_latency: assert property (@(posedge clk) disable iff (rst)
		i_start |-> ##(DIV_STEPS + 2) o_done);

endmodule

// File: tb.f
source/exec_pkg.sv
source/alu_unit.sv
source/iter_divider.sv
source/exec_control.sv
source/exec_unit.sv
testbench/tb_exec_unit.sv

// File: testbench/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit;
	import exec_pkg::*;

	localparam int WAIT_LIMIT = 4 * DIV_STEPS;

	logic             clk;
	logic             rst;
	logic             i_req;
	exec_cmd_t        i_cmd;
	logic             o_ack;
	logic [XLEN-1:0]  o_result;

	logic [31:0]      lfsr_q;
	int               check_count;
	int               mismatch_count;
	int               other_errors;
	string            name_q[$];      // Commands in flight, oldest first.
	logic [XLEN-1:0]  exp_q[$];
	logic             ack_prev;
	logic [XLEN-1:0]  held_result;

	exec_op_e         div_ops [4];
	exec_op_e         cmp_ops [5];
	exec_op_e         all_ops [11];
	logic [XLEN-1:0]  edge_vals [4];

	exec_unit dut (
		.clk      (clk),
		.rst      (rst),
		.i_req    (i_req),
		.i_cmd    (i_cmd),
		.o_ack    (o_ack),
		.o_result (o_result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Fibonacci LFSR, taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			bits = {bits[30:0], lfsr_q[0]};
		end
		take_bits = bits;
	endfunction

	// RISC-V semantics, including divide by zero and signed overflow.
	function automatic logic [XLEN-1:0] ref_exec(input exec_op_e op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic signed [XLEN-1:0] sa;
		logic signed [XLEN-1:0] sb;
		logic                   sign_ovf;
		sa = a;
		sb = b;
		sign_ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (op)
			OP_ADD:  ref_exec = a + b;
			OP_SUB:  ref_exec = a - b;
			OP_SLT:  ref_exec = (sa < sb) ? 32'd1 : 32'd0;
			OP_SLTU: ref_exec = (a < b) ? 32'd1 : 32'd0;
			OP_XOR:  ref_exec = a ^ b;
			OP_OR:   ref_exec = a | b;
			OP_AND:  ref_exec = a & b;
			OP_DIV: begin
				if (b == '0) ref_exec = '1;
				else if (sign_ovf) ref_exec = a;
				else ref_exec = sa / sb;
			end
			OP_DIVU: ref_exec = (b == '0) ? '1 : a / b;
			OP_REM: begin
				if (b == '0) ref_exec = a;
				else if (sign_ovf) ref_exec = '0;
				else ref_exec = sa % sb;
			end
			OP_REMU: ref_exec = (b == '0) ? a : a % b;
			default: ref_exec = '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [XLEN-1:0] expected,
		input logic [XLEN-1:0] actual);
		check_count++;
		if (actual !== expected) begin
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic print_counts();
		$display("checks %0d, mismatches %0d, other errors %0d",
			check_count, mismatch_count, other_errors);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timed out waiting for %s.", what);
		other_errors++;
		print_counts();
		$display("TB FAILED");
		$finish;
	endtask

	// Called on a falling edge; returns on a falling edge with o_ack low.
	task automatic issue_command(input exec_op_e op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b, input int hold, input string name);
		int cnt;
		int exp_lat;
		name_q.push_back(name);
		exp_q.push_back(ref_exec(op, a, b));
		i_cmd.op = op;
		i_cmd.operand_a = a;
		i_cmd.operand_b = b;
		i_req = 1'b1;
		cnt = 0;
		while (!o_ack) begin
			if (cnt >= WAIT_LIMIT) abort_on_timeout({"o_ack to rise in ", name});
			else begin
				@(negedge clk);
				cnt++;
			end
		end
		exp_lat = (op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) ? DIV_STEPS + 3 : 2;
		check_value({name, " latency"}, exp_lat, cnt - 1);    // First edge samples req.
		for (int i = 0; i < hold; i++) begin
			@(negedge clk);
			check_value({name, " ack held"}, 1, o_ack);
		end
		i_req = 1'b0;
		cnt = 0;
		while (o_ack) begin
			if (cnt >= WAIT_LIMIT) abort_on_timeout({"o_ack to fall in ", name});
			else begin
				@(negedge clk);
				cnt++;
			end
		end
		check_value({name, " ack fall"}, 1, cnt);
	endtask

	// Compares each result when o_ack rises and checks that it holds.
	always @(negedge clk) begin
		if (rst) begin
			ack_prev <= 1'b0;
		end else begin
			if (o_ack && !ack_prev) begin
				if (exp_q.size() == 0) begin
					$display("o_ack rose with no command outstanding.");
					other_errors++;
				end else begin
					check_value(name_q.pop_front(), exp_q.pop_front(), o_result);
				end
			end else if (o_ack && ack_prev) begin
				check_value("result hold", held_result, o_result);
			end
			ack_prev <= o_ack;
			held_result <= o_result;
		end
	end

	initial begin
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] mag;
		exec_op_e        op;
		rst = 1'b1;
		i_req = 1'b0;
		i_cmd = '0;
		lfsr_q = 32'he5cd_157b;
		check_count = 0;
		mismatch_count = 0;
		other_errors = 0;
		div_ops = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
		cmp_ops = '{OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND};
		all_ops = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND,
			OP_DIV, OP_DIVU, OP_REM, OP_REMU};
		edge_vals = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

		repeat (3) @(negedge clk);
		rst = 1'b0;
		check_value("ack after reset", 0, o_ack);

		for (int n = 0; n < 16; n++) begin
			a = take_bits(32);
			b = take_bits(32);
			issue_command(OP_ADD, a, b, 1, $sformatf("ADD #%0d", n));
			issue_command(OP_SUB, a, b, 1, $sformatf("SUB #%0d", n));
		end
		issue_command(OP_ADD, 32'hffff_ffff, 32'h1, 1, "ADD carry all blocks");
		issue_command(OP_ADD, 32'h00ff_ff80, 32'h80, 1, "ADD carry two blocks");
		issue_command(OP_ADD, 32'h7fff_ffff, 32'h1, 1, "ADD into sign");
		issue_command(OP_SUB, 32'h0, 32'h1, 1, "SUB borrow all blocks");

		foreach (cmp_ops[k]) begin
			for (int i = 0; i < 4; i++)
				for (int j = 0; j < 4; j++)
					issue_command(cmp_ops[k], edge_vals[i], edge_vals[j], 1,
						$sformatf("%s edge %0d,%0d", cmp_ops[k].name(), i, j));
			for (int n = 0; n < 6; n++)
				issue_command(cmp_ops[k], take_bits(32), take_bits(32), 1,
					$sformatf("%s #%0d", cmp_ops[k].name(), n));
		end

		foreach (div_ops[k]) begin
			for (int combo = 0; combo < 4; combo++) begin
				for (int n = 0; n < 2; n++) begin
					a = take_bits(32);
					a[XLEN-1] = combo[1];
					mag = take_bits(31) >> take_bits(5);    // Spread of divisor sizes.
					b = combo[0] ? -mag : mag;
					issue_command(div_ops[k], a, b, 1,
						$sformatf("%s signs %0d #%0d", div_ops[k].name(), combo, n));
				end
			end
		end

		foreach (div_ops[k]) begin
			for (int i = 0; i < 4; i++)
				issue_command(div_ops[k], edge_vals[i], 32'h0, 1,
					$sformatf("%s by zero %0d", div_ops[k].name(), i));
			issue_command(div_ops[k], take_bits(32), 32'h0, 1,
				$sformatf("%s random by zero", div_ops[k].name()));
			issue_command(div_ops[k], 32'h8000_0000, 32'hffff_ffff, 1,
				$sformatf("%s min by -1", div_ops[k].name()));
		end

		for (int n = 0; n < 8; n++) begin
			op = all_ops[take_bits(4) % 11];
			issue_command(op, take_bits(32), take_bits(32), 2 + take_bits(3),
				$sformatf("%s held #%0d", op.name(), n));
			issue_command(OP_ADD, take_bits(32), take_bits(32), 1,
				$sformatf("ADD after hold #%0d", n));
		end

		repeat (2) @(negedge clk);
		if (exp_q.size() != 0) begin
			$display("%0d results never arrived.", exp_q.size());
			other_errors++;
		end
		print_counts();
		if (mismatch_count + other_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
